// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_eeprom_ctrl
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := src/eeprom_macros.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)

// ==== sim.f ====
+incdir+src
src/eeprom_pkg.sv
src/byte_link_if.sv
src/i2c_byte_engine.sv
src/eeprom_access_fsm.sv
src/eeprom_ctrl.sv
test/tb_clock.sv
test/eeprom_model.sv
test/eeprom_checker.sv
test/tb_eeprom_ctrl.sv

// ==== src/byte_link_if.sv ====
`timescale 1ns/10ps
`include "eeprom_macros.svh"

// four-phase req/ack link between sequencer and byte engine
interface byte_link_if;
    import eeprom_pkg::*;

    logic                  req;
    byte_cmd_e             cmd;
    logic [`EE_DATA_W-1:0] tx_byte;
    logic                  master_ack; // 0 ack, 1 nack after a read
    logic                  ack;
    logic [`EE_DATA_W-1:0] rx_byte;
    logic                  slave_nack; // sampled ack bit after a write

    modport master (
        output req, cmd, tx_byte, master_ack,
        input  ack, rx_byte, slave_nack
    );

    modport slave (
        input  req, cmd, tx_byte, master_ack,
        output ack, rx_byte, slave_nack
    );

endinterface

// ==== src/eeprom_access_fsm.sv ====
`timescale 1ns/10ps
`include "eeprom_macros.svh"

module eeprom_access_fsm (
    input  logic                  CLK,
    input  logic                  RESET,
    byte_link_if.master           link,
    input  logic                  host_req,
    input  logic                  host_we,
    input  logic [`EE_ADDR_W-1:0] host_addr,
    input  logic [`EE_DATA_W-1:0] host_wdata,
    output logic                  host_ack,
    output logic [`EE_DATA_W-1:0] host_rdata,
    output logic                  host_err
);
    import eeprom_pkg::*;

    access_state_e         state;
    access_state_e         next_state;
    logic                  wf; // write flag, low for a read
    logic [`EE_ADDR_W-1:0] addr_q;
    logic [`EE_DATA_W-1:0] wdata_q;
    logic [2:0]            addr_hi;
    logic                  step_done;

    assign addr_hi   = addr_q[`EE_ADDR_W-1 -: 3];
    assign step_done = link.req && link.ack;

    // command for the current step and its successor
    always_comb begin
        link.cmd        = CMD_WRITE;
        link.tx_byte    = '0;
        link.master_ack = 1'b1; // single byte read ends with nack
        next_state      = state;
        case (state)
            START: begin
                link.cmd   = CMD_START;
                next_state = CTRL_W;
            end
            CTRL_W: begin
                link.tx_byte = {`EE_DEV_CODE, addr_hi, 1'b0};
                next_state   = ADDR;
            end
            ADDR: begin
                link.tx_byte = addr_q[7:0];
                next_state   = wf ? DATA_W : RESTART;
            end
            DATA_W: begin
                link.tx_byte = wdata_q;
                next_state   = STOP;
            end
            RESTART: begin
                link.cmd   = CMD_START;
                next_state = CTRL_R;
            end
            CTRL_R: begin
                link.tx_byte = {`EE_DEV_CODE, addr_hi, 1'b1};
                next_state   = DATA_R;
            end
            DATA_R: begin
                link.cmd   = CMD_READ;
                next_state = STOP;
            end
            STOP: begin
                link.cmd   = CMD_STOP;
                next_state = DONE;
            end
            default: next_state = state;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= IDLE;
            link.req <= 1'b0;
            host_ack <= 1'b0;
            host_err <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (host_req) begin
                        host_err <= 1'b0;
                        state    <= START;
                    end
                end
                DONE: begin
                    if (!host_req) begin
                        host_ack <= 1'b0;
                        state    <= IDLE;
                    end
                end
                default: begin
                    if (!link.req && !link.ack) begin
                        link.req <= 1'b1; // previous ack must be low first
                    end else if (step_done) begin
                        link.req <= 1'b0;
                        if (state == STOP) begin
                            host_ack <= 1'b1;
                            state    <= DONE;
                        end else if (link.slave_nack) begin
                            host_err <= 1'b1; // abort with a stop
                            state    <= STOP;
                        end else begin
                            state <= next_state;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == IDLE && host_req) begin
            wf      <= host_we;
            addr_q  <= host_addr;
            wdata_q <= host_wdata;
        end
        if (state == DATA_R && step_done)
            host_rdata <= link.rx_byte;
    end

    a_onehot: assert property (@(posedge CLK) disable iff (RESET) $onehot(state));

    // engine still holds ack for the finished stop step
    a_ack_in_done: assert property (@(posedge CLK) disable iff (RESET)
        $rose(host_ack) |-> state == DONE && link.ack && !link.req);

endmodule

// ==== src/eeprom_ctrl.sv ====
`timescale 1ns/10ps
`include "eeprom_macros.svh"

module eeprom_ctrl (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  host_req,
    input  logic                  host_we,
    input  logic [`EE_ADDR_W-1:0] host_addr,
    input  logic [`EE_DATA_W-1:0] host_wdata,
    output logic                  host_ack,
    output logic [`EE_DATA_W-1:0] host_rdata,
    output logic                  host_err,
    output logic                  scl,
    output logic                  sda_pull, // open-drain low enable
    input  logic                  sda_in
);

    byte_link_if link ();

    eeprom_access_fsm u_fsm (
        .CLK        (CLK),
        .RESET      (RESET),
        .link       (link.master),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .host_err   (host_err)
    );

    i2c_byte_engine u_engine (
        .CLK      (CLK),
        .RESET    (RESET),
        .link     (link.slave),
        .scl      (scl),
        .sda_pull (sda_pull),
        .sda_in   (sda_in)
    );

endmodule

// ==== src/eeprom_macros.svh ====
`ifndef EEPROM_MACROS_SVH
`define EEPROM_MACROS_SVH

// word address width, 2K x 8 part
`define EE_ADDR_W 11

// data byte width
`define EE_DATA_W 8

// device type code in the control byte
`define EE_DEV_CODE 4'b1010

// CLK cycles per quarter of an SCL period
// full SCL period is 4 * EE_SCL_QDIV cycles
`define EE_SCL_QDIV 2

`endif

// ==== src/eeprom_pkg.sv ====
package eeprom_pkg;

    // byte engine commands
    typedef enum logic [1:0] {
        CMD_START = 2'd0, // start or repeated start
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2, // 8 bits out, slave ack in
        CMD_READ  = 2'd3  // 8 bits in, master ack out
    } byte_cmd_e;

    // access sequencer states, one-hot
    typedef enum logic [9:0] {
        IDLE    = 10'b00_0000_0001,
        START   = 10'b00_0000_0010,
        CTRL_W  = 10'b00_0000_0100,
        ADDR    = 10'b00_0000_1000,
        DATA_W  = 10'b00_0001_0000,
        RESTART = 10'b00_0010_0000,
        CTRL_R  = 10'b00_0100_0000,
        DATA_R  = 10'b00_1000_0000,
        STOP    = 10'b01_0000_0000,
        DONE    = 10'b10_0000_0000
    } access_state_e;

endpackage

// ==== src/i2c_byte_engine.sv ====
`timescale 1ns/10ps
`include "eeprom_macros.svh"

module i2c_byte_engine (
    input  logic       CLK,
    input  logic       RESET,
    byte_link_if.slave link,
    output logic       scl,
    output logic       sda_pull,
    input  logic       sda_in
);
    import eeprom_pkg::*;

    localparam int QW = $clog2(`EE_SCL_QDIV + 1);
    localparam logic [QW-1:0] QLAST = QW'(`EE_SCL_QDIV - 1);

    logic                  busy;
    logic [QW-1:0]         qcnt;    // cycles within a quarter
    logic [1:0]            quarter; // 0-1 scl low, 2-3 scl high
    logic [3:0]            bit_idx; // 0..7 data, 8 ack
    byte_cmd_e             cmd_q;
    logic [`EE_DATA_W-1:0] shreg;
    logic                  mack_q;
    logic                  ctl_op;
    logic                  ack_bit;
    logic                  q_end;
    logic                  bit_end;
    logic                  op_end;
    logic                  q1_pull;

    assign ctl_op  = (cmd_q == CMD_START) || (cmd_q == CMD_STOP);
    assign ack_bit = (bit_idx == 4'(`EE_DATA_W));
    assign q_end   = busy && (qcnt == QLAST);
    assign bit_end = q_end && (quarter == 2'd3);
    assign op_end  = bit_end && (ctl_op || ack_bit);

    // sda level set in the middle of scl low
    always_comb begin
        case (cmd_q)
            CMD_START: q1_pull = 1'b0; // release before the high phase
            CMD_STOP:  q1_pull = 1'b1;
            CMD_WRITE: q1_pull = ack_bit ? 1'b0 : ~shreg[`EE_DATA_W-1];
            default:   q1_pull = ack_bit ? ~mack_q : 1'b0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy     <= 1'b0;
            qcnt     <= '0;
            quarter  <= 2'd0;
            bit_idx  <= 4'd0;
            scl      <= 1'b1;
            sda_pull <= 1'b0;
            link.ack <= 1'b0;
        end else if (!busy) begin
            if (link.req && !link.ack) begin
                busy    <= 1'b1;
                qcnt    <= '0;
                quarter <= 2'd0;
                bit_idx <= 4'd0;
                scl     <= 1'b0;
            end else if (link.ack && !link.req) begin
                link.ack <= 1'b0;
            end
        end else if (q_end) begin
            qcnt    <= '0;
            quarter <= quarter + 2'd1;
            case (quarter)
                2'd0: sda_pull <= q1_pull;
                2'd1: scl <= 1'b1;
                2'd2: begin
                    if (ctl_op)
                        sda_pull <= (cmd_q == CMD_START); // edge while scl high
                end
                default: begin
                    if (op_end) begin
                        busy     <= 1'b0;
                        link.ack <= 1'b1;
                    end else begin
                        bit_idx <= bit_idx + 4'd1;
                        scl     <= 1'b0;
                    end
                end
            endcase
        end else begin
            qcnt <= qcnt + 1'b1;
        end
    end

    // command capture, shifting and sampling
    always_ff @(posedge CLK) begin
        if (!busy && link.req && !link.ack) begin
            cmd_q           <= link.cmd;
            shreg           <= link.tx_byte;
            mack_q          <= link.master_ack;
            link.slave_nack <= 1'b0;
        end else if (q_end && quarter == 2'd2 && !ctl_op) begin
            if (cmd_q == CMD_WRITE && ack_bit)
                link.slave_nack <= sda_in;
            else if (cmd_q == CMD_READ && !ack_bit)
                shreg <= {shreg[`EE_DATA_W-2:0], sda_in}; // msb first
        end else if (bit_end && cmd_q == CMD_WRITE && !ack_bit) begin
            shreg <= {shreg[`EE_DATA_W-2:0], 1'b0};
        end
        if (op_end && cmd_q == CMD_READ)
            link.rx_byte <= shreg;
    end

    // data only moves while scl is low, apart from start and stop edges
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !(busy && ctl_op)) |-> $stable(sda_pull));

    a_ack_req: assert property (@(posedge CLK) disable iff (RESET)
        $rose(link.ack) |-> link.req);

endmodule

// ==== test/eeprom_checker.sv ====
`timescale 1ns/10ps

// compares each completed access against the stimulus line
module eeprom_checker (
    input  logic       clk,
    input  logic       reset,
    input  logic       host_req,
    input  logic       host_ack,
    input  logic [7:0] host_rdata,
    input  logic       host_err,
    input  int         test_idx,
    input  logic [7:0] exp_rdata,
    input  logic       exp_err,
    input  logic       check_rdata,
    input  int         stop_count,
    output int         pass_count,
    output int         fail_count
);

    logic ack_q;
    logic req_q;
    int   done_count;

    initial begin
        ack_q      = 1'b0;
        req_q      = 1'b0;
        done_count = 0;
        pass_count = 0;
        fail_count = 0;
    end

    always @(posedge clk) begin
        int errs;
        errs = 0;
        if (!reset) begin
            if (host_ack && !ack_q) begin
                if (host_err !== exp_err) begin
                    $display("[FAIL] test %0d host_err expected %h got %h",
                             test_idx, exp_err, host_err);
                    errs++;
                end
                if (check_rdata && host_rdata !== exp_rdata) begin
                    $display("[FAIL] test %0d host_rdata expected %h got %h",
                             test_idx, exp_rdata, host_rdata);
                    errs++;
                end
                if (stop_count != done_count + 1) begin
                    $display("test %0d: the EEPROM saw %0d stop conditions after %0d accesses",
                             test_idx, stop_count, done_count + 1);
                    errs++;
                end
                done_count <= done_count + 1;
                if (errs == 0) begin
                    $display("[PASS] test %0d", test_idx);
                    pass_count <= pass_count + 1;
                end else begin
                    fail_count <= fail_count + 1;
                end
            end
            // ack must follow req down one cycle later, never sooner
            if (!host_ack && ack_q && req_q) begin
                $display("test %0d: host_ack dropped while host_req was still high", test_idx);
                fail_count <= fail_count + 1;
            end
            if (host_ack && ack_q && !req_q) begin
                $display("test %0d: host_ack stayed high after host_req fell", test_idx);
                fail_count <= fail_count + 1;
            end
        end
        ack_q <= host_ack;
        req_q <= host_req;
    end

endmodule

// ==== test/eeprom_model.sv ====
`timescale 1ns/10ps

// two-wire EEPROM slave, oversampled on the testbench clock
module eeprom_model (
    input  logic clk,
    input  logic scl,
    input  logic sda,        // resolved bus level
    input  logic force_nack, // refuse the control byte
    output logic sda_pull,
    output int   stop_count
);

    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_RX   = 3'd1;
    localparam logic [2:0] S_ACK  = 3'd2;
    localparam logic [2:0] S_TX   = 3'd3;

    logic [7:0]  mem [0:2047];
    logic [2:0]  st;
    logic        scl_q;
    logic        sda_q;
    logic [3:0]  bit_cnt;
    logic [1:0]  byte_idx; // 0 control, 1 address low, 2 data
    logic [7:0]  shreg;
    logic [10:0] addr;
    logic        rw;

    initial begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'h00;
        st         = S_IDLE;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
        sda_pull   = 1'b0;
        stop_count = 0;
        bit_cnt    = 4'd0;
        byte_idx   = 2'd0;
        shreg      = 8'h00;
        addr       = 11'h000;
        rw         = 1'b0;
    end

    always @(posedge clk) begin
        scl_q <= scl;
        sda_q <= sda;
        if (scl && scl_q && sda_q && !sda) begin // start or restart
            st       <= S_RX;
            bit_cnt  <= 4'd0;
            byte_idx <= 2'd0;
            sda_pull <= 1'b0;
        end else if (scl && scl_q && !sda_q && sda) begin // stop
            st         <= S_IDLE;
            sda_pull   <= 1'b0;
            stop_count <= stop_count + 1;
        end else if (scl && !scl_q) begin
            if (st == S_RX) begin
                shreg   <= {shreg[6:0], sda};
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else if (!scl && scl_q) begin
            case (st)
                S_RX: begin
                    if (bit_cnt == 4'd8) begin
                        bit_cnt <= 4'd0;
                        if (byte_idx != 2'd3)
                            byte_idx <= byte_idx + 2'd1;
                        if (byte_idx == 2'd0) begin
                            if (shreg[7:4] == 4'b1010 && !force_nack) begin
                                addr[10:8] <= shreg[3:1];
                                rw         <= shreg[0];
                                sda_pull   <= 1'b1;
                                st         <= S_ACK;
                            end else begin
                                st <= S_IDLE; // no ack, bus stays released
                            end
                        end else begin
                            if (byte_idx == 2'd1)
                                addr[7:0] <= shreg;
                            else if (byte_idx == 2'd2)
                                mem[addr] <= shreg;
                            sda_pull <= 1'b1;
                            st       <= S_ACK;
                        end
                    end
                end
                S_ACK: begin
                    if (rw) begin
                        shreg    <= mem[addr];
                        sda_pull <= ~mem[addr][7]; // msb first
                        bit_cnt  <= 4'd1;
                        st       <= S_TX;
                    end else begin
                        sda_pull <= 1'b0;
                        st       <= S_RX;
                    end
                end
                S_TX: begin
                    if (bit_cnt == 4'd8) begin
                        sda_pull <= 1'b0; // master acks now
                        st       <= S_IDLE;
                    end else begin
                        sda_pull <= ~shreg[6];
                        shreg    <= {shreg[6:0], 1'b0};
                        bit_cnt  <= bit_cnt + 4'd1;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== test/eeprom_stimulus.txt ====
// op(1 write, 0 read) _ addr _ wdata _ expected rdata _ force nack _ expected err
// op f ends the list
1_07f_a5_00_0_0
0_07f_00_a5_0_0
1_123_11_00_0_0
1_223_22_00_0_0
1_723_77_00_0_0
0_123_00_11_0_0
0_223_00_22_0_0
0_723_00_77_0_0
0_555_00_00_0_0
1_07f_3c_00_1_1
0_07f_00_a5_0_0
0_123_00_00_1_1
0_123_00_11_0_0
1_4c2_e7_00_0_0
0_4c2_00_e7_0_0
f_000_00_00_0_0

// ==== test/tb_clock.sv ====
`timescale 1ns/10ps

// 4 ns clock, reset held for the first 4 cycles
module tb_clock (
    output logic CLK,
    output logic RESET
);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial begin
        RESET = 1'b1;
        repeat (4) @(posedge CLK);
        #1 RESET = 1'b0; // released just after the edge
    end

endmodule

// ==== test/tb_eeprom_ctrl.sv ====
`timescale 1ns/10ps
`include "eeprom_macros.svh"

module tb_eeprom_ctrl;

    logic        CLK;
    logic        RESET;
    logic        host_req;
    logic        host_we;
    logic [10:0] host_addr;
    logic [7:0]  host_wdata;
    logic        host_ack;
    logic [7:0]  host_rdata;
    logic        host_err;
    logic        scl;
    logic        sda_pull;
    logic        model_pull;
    logic        sda_bus;
    logic        force_nack;
    logic [7:0]  exp_rdata;
    logic        exp_err;
    logic        check_rdata;
    int          test_idx;
    int          stop_count;
    int          pass_count;
    int          fail_count;
    int          num_tests;
    logic [39:0] stim [0:63]; // op, addr, wdata, expected, nack, err
    logic [31:0] rnd;

    assign sda_bus = ~(sda_pull | model_pull); // wired-AND

    tb_clock u_clock (.CLK(CLK), .RESET(RESET));

    eeprom_ctrl dut (
        .CLK        (CLK),
        .RESET      (RESET),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .host_err   (host_err),
        .scl        (scl),
        .sda_pull   (sda_pull),
        .sda_in     (sda_bus)
    );

    eeprom_model u_model (
        .clk        (CLK),
        .scl        (scl),
        .sda        (sda_bus),
        .force_nack (force_nack),
        .sda_pull   (model_pull),
        .stop_count (stop_count)
    );

    eeprom_checker u_checker (
        .clk         (CLK),
        .reset       (RESET),
        .host_req    (host_req),
        .host_ack    (host_ack),
        .host_rdata  (host_rdata),
        .host_err    (host_err),
        .test_idx    (test_idx),
        .exp_rdata   (exp_rdata),
        .exp_err     (exp_err),
        .check_rdata (check_rdata),
        .stop_count  (stop_count),
        .pass_count  (pass_count),
        .fail_count  (fail_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        host_req    = 1'b0;
        host_we     = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        force_nack  = 1'b0;
        exp_rdata   = '0;
        exp_err     = 1'b0;
        check_rdata = 1'b0;
        test_idx    = 0;
        num_tests   = 0;
        rnd         = 32'had73;
        for (int i = 0; i < 64; i++)
            stim[i] = 40'hf0_0000_0000; // end marker
        $readmemh("test/eeprom_stimulus.txt", stim);
        while (num_tests < 64 && stim[num_tests][39:36] != 4'hf)
            num_tests++;

        @(negedge RESET);
        for (int i = 0; i < num_tests; i++) begin
            @(posedge CLK);
            #1;
            test_idx    = i;
            host_we     = stim[i][36];
            host_addr   = stim[i][34:24];
            host_wdata  = stim[i][23:16];
            exp_rdata   = stim[i][15:8];
            force_nack  = stim[i][4];
            exp_err     = stim[i][0];
            check_rdata = !stim[i][36] && !stim[i][0];
            host_req    = 1'b1;
            do begin
                @(posedge CLK);
                #1;
            end while (!host_ack);
            rnd = xorshift32(rnd);
            repeat (rnd % 5) @(posedge CLK); // hold req a little longer
            #1 host_req = 1'b0;
            do begin
                @(posedge CLK);
                #1;
            end while (host_ack);
            force_nack = 1'b0;
        end
        repeat (2) @(posedge CLK);

        $display("%0d passed, %0d failed of %0d", pass_count, fail_count, num_tests);
        if (fail_count == 0 && pass_count == num_tests) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog sized from the stimulus length
    initial begin
        longint limit;
        @(negedge RESET);
        limit = longint'(num_tests) * 300 * `EE_SCL_QDIV * 4 + 2000;
        #(limit);
        $display("timeout: the accesses did not finish within %0d ns", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule
